/* Bender.yml */
package:
  name: gl_top

sources:
  - gl_pkg.sv
  - graduation_list.sv
  - exec_pipe.sv
  - commit_unit.sv
  - gl_top.sv
  - target: test
    files:
      - gl_checker.sv
      - tb_gl_top.sv

/* commit_unit.sv */
`timescale 1ns/10ps

module commit_unit import gl_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  gl_instruction_t instruction_i,   // Head from the graduation list
    input  gl_index_t       commit_index_i,
    input  logic            empty_i,
    output logic            read_head_o,
    output logic            flush_commit_o,
    output commit_t         commit_o,
    output logic [31:0]     retired_count_o
);

    logic        exc_commit;
    logic        good_commit;
    logic [31:0] retired_q;

    // Ask for the head whenever something is stored
    assign read_head_o = ~empty_i;

    assign exc_commit  = instruction_i.valid & instruction_i.exc_valid;
    assign good_commit = instruction_i.valid & ~instruction_i.exc_valid;

    assign flush_commit_o = exc_commit;  // Same cycle as the commit

    always_comb begin
        commit_o.valid     = instruction_i.valid;
        commit_o.index     = commit_index_i;
        commit_o.pc        = instruction_i.pc;
        commit_o.result    = instruction_i.result;
        commit_o.exc_valid = exc_commit;
    end

    // Retired instructions without an exception
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            retired_q <= '0;
        end else if (good_commit) begin
            retired_q <= retired_q + 32'd1;
        end
    end

    assign retired_count_o = retired_q;

endmodule

/* exec_pipe.sv */
`timescale 1ns/10ps

module exec_pipe import gl_pkg::*; #(
    parameter unit_e       UNIT    = ALU_UNIT,
    parameter int unsigned LATENCY = 1
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  dispatch_t dispatch_i,
    input  logic      accept_i,  // Dispatch handshake this cycle
    input  gl_index_t index_i,   // Entry given by the graduation list
    input  logic      flush_i,
    output wb_t       wb_o
);

    // Operation handled by this pipe
    localparam instr_type_e UNIT_OP = (UNIT == ALU_UNIT) ? OP_ADD : OP_MUL;

    logic               take;
    data_t              result;
    logic               exc;
    wb_t                entry_wb;
    logic [LATENCY-1:0] valid_q;
    wb_t                stage_q [LATENCY];

    assign take = accept_i & dispatch_i.valid & (dispatch_i.instr_type == UNIT_OP);

    generate
        if (UNIT == ALU_UNIT) begin : g_alu
            assign result = dispatch_i.src_a + dispatch_i.src_b;
            // Operands agree in sign but the sum does not
            assign exc    = (dispatch_i.src_a[DATA_W-1] == dispatch_i.src_b[DATA_W-1]) &
                            (result[DATA_W-1] != dispatch_i.src_a[DATA_W-1]);
        end else begin : g_mul
            assign result = dispatch_i.src_a * dispatch_i.src_b; // Low half only
            assign exc    = 1'b0;
        end
    endgenerate

    always_comb begin
        entry_wb.valid     = take;
        entry_wb.index     = index_i;
        entry_wb.result    = result;
        entry_wb.exc_valid = exc;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;   // Kill everything in flight
        end else begin
            valid_q[0] <= entry_wb.valid;
            for (int k = 1; k < LATENCY; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        stage_q[0] <= entry_wb;
        for (int k = 1; k < LATENCY; k++) begin
            stage_q[k] <= stage_q[k-1];
        end
    end

    always_comb begin
        wb_o       = stage_q[LATENCY-1];
        wb_o.valid = valid_q[LATENCY-1];
    end

endmodule

/* gl_checker.sv */
`timescale 1ns/10ps

module gl_checker import gl_pkg::*; #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  dispatch_t   dispatch_i,
    input  logic        dispatch_ready_i,
    input  gl_index_t   assigned_index_i,
    input  commit_t     commit_i,
    input  logic [31:0] retired_count_i,
    input  logic        done_i,           // Stimulus over and list drained
    output int          error_count_o,
    output int          good_count_o,
    output int          exc_count_o,
    output int          pending_o
);

    commit_t   expected_q [$];  // Oldest outstanding instruction first
    gl_index_t exp_tail;
    int        full_cycles;     // Cycles with dispatch held off by a full list
    logic      final_done;

    // Retirement record of one instruction from the operation rules
    function automatic commit_t expected_commit(dispatch_t d, gl_index_t idx);
        commit_t     c;
        longint      sum;
        logic [63:0] prod;
        c       = '0;
        c.valid = 1'b1;
        c.index = idx;
        c.pc    = d.pc;
        sum     = longint'($signed(d.src_a)) + longint'($signed(d.src_b));
        prod    = {32'd0, d.src_a} * {32'd0, d.src_b};
        case (d.instr_type)
            OP_ADD: begin
                c.result    = sum[31:0];
                // Exact sum outside the 32-bit signed range
                c.exc_valid = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
            end
            OP_MUL:  c.result = prod[31:0];
            default: c.result = d.src_a;  // Store
        endcase
        return c;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp_val);
        if (got !== exp_val) begin
            error_count_o++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp_val, $time);
        end
    endtask

    always @(negedge clk_i) begin : monitor
        commit_t front;
        logic    exp_flush;
        int      stored;
        if (!rstn_i) begin
            expected_q.delete();
            exp_tail      = '0;
            full_cycles   = 0;
            final_done    = 1'b0;
            error_count_o = 0;
            good_count_o  = 0;
            exc_count_o   = 0;
        end else begin
            exp_flush = commit_i.valid && (expected_q.size() > 0) && expected_q[0].exc_valid;
            stored    = expected_q.size() - int'(commit_i.valid);  // Head left the list already
            check_value("dispatch_ready_o", dispatch_ready_i,
                        (stored < NUM_ENTRIES - 1) && !exp_flush);
            check_value("retired_count_o", retired_count_i, good_count_o);
            if (!dispatch_ready_i && !exp_flush) full_cycles++;

            if (commit_i.valid) begin
                if (expected_q.size() == 0) begin
                    error_count_o++;
                    $display("Commit of pc %h with no instruction outstanding", commit_i.pc);
                end else begin
                    front = expected_q.pop_front();
                    check_value("commit_o.index", commit_i.index, front.index);
                    check_value("commit_o.pc", commit_i.pc, front.pc);
                    check_value("commit_o.result", commit_i.result, front.result);
                    check_value("commit_o.exc_valid", commit_i.exc_valid, front.exc_valid);
                    if (front.exc_valid) begin
                        exc_count_o++;
                        expected_q.delete();  // Everything younger is flushed
                        exp_tail = '0;
                    end else begin
                        good_count_o++;
                    end
                end
            end

            if (dispatch_i.valid && dispatch_ready_i) begin
                check_value("assigned_index_o", assigned_index_i, exp_tail);
                expected_q.push_back(expected_commit(dispatch_i, exp_tail));
                exp_tail = gl_index_t'((exp_tail + 1) % NUM_ENTRIES);
            end

            if (done_i && !final_done) begin
                final_done = 1'b1;
                if (full_cycles == 0) begin
                    error_count_o++;
                    $display("The list never filled up, dispatch_ready_o stayed high");
                end
                if (exc_count_o == 0) begin
                    error_count_o++;
                    $display("No commit with an exception was seen");
                end
            end
        end
        pending_o = expected_q.size();
    end

endmodule

/* gl_pkg.sv */
package gl_pkg;

    // Basic widths
    localparam int unsigned DATA_W     = 32;
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned GL_INDEX_W = 4;    // Up to 16 list entries
    localparam int unsigned NUM_WB     = 2;    // One writeback port per pipe

    typedef logic [DATA_W-1:0]     data_t;     // Operand and result
    typedef logic [ADDR_W-1:0]     addr_t;     // Program counter
    typedef logic [GL_INDEX_W-1:0] gl_index_t; // Graduation list entry

    // Operations known to the subsystem
    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_MUL   = 2'd1,
        OP_STORE = 2'd2
    } instr_type_e;

    // Kind of execution pipe
    typedef enum logic {
        ALU_UNIT = 1'b0,
        MUL_UNIT = 1'b1
    } unit_e;

    // Instruction as it arrives from the front end
    typedef struct packed {
        logic        valid;
        instr_type_e instr_type;
        addr_t       pc;
        data_t       src_a;
        data_t       src_b;
    } dispatch_t;

    // Graduation list entry, also used for the head output
    typedef struct packed {
        logic        valid;
        instr_type_e instr_type;
        addr_t       pc;
        data_t       result;
        logic        exc_valid;
    } gl_instruction_t;

    // Result returned by a pipe
    typedef struct packed {
        logic      valid;
        gl_index_t index;
        data_t     result;
        logic      exc_valid;
    } wb_t;

    // Retired instruction
    typedef struct packed {
        logic      valid;
        gl_index_t index;
        addr_t     pc;
        data_t     result;
        logic      exc_valid;
    } commit_t;

endpackage

/* gl_top.sv */
`timescale 1ns/10ps

module gl_top import gl_pkg::*; #(
    parameter int unsigned NUM_ENTRIES = 16,
    parameter int unsigned MUL_LATENCY = 3
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  dispatch_t   dispatch_i,
    output logic        dispatch_ready_o,
    output gl_index_t   assigned_index_o,
    output commit_t     commit_o,
    output logic [31:0] retired_count_o
);

    logic              accept;
    logic              gl_full;
    logic              gl_empty;
    logic              read_head;
    logic              flush_commit;
    gl_instruction_t   gl_in;
    gl_instruction_t   gl_head;
    gl_index_t         commit_index;
    wb_t [NUM_WB-1:0]  wb;

    // No room or flushing stops dispatch
    assign dispatch_ready_o = ~gl_full & ~flush_commit;
    assign accept           = dispatch_i.valid & dispatch_ready_o;

    // Entry written at the tail; a store carries its first operand as result
    always_comb begin
        gl_in.valid      = accept;
        gl_in.instr_type = dispatch_i.instr_type;
        gl_in.pc         = dispatch_i.pc;
        gl_in.result     = (dispatch_i.instr_type == OP_STORE) ? dispatch_i.src_a : '0;
        gl_in.exc_valid  = 1'b0;
    end

    graduation_list #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_graduation_list (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .instruction_i    (gl_in),
        .read_head_i      (read_head),
        .wb_i             (wb),
        .flush_commit_i   (flush_commit),
        .assigned_index_o (assigned_index_o),
        .instruction_o    (gl_head),
        .commit_index_o   (commit_index),
        .full_o           (gl_full),
        .empty_o          (gl_empty)
    );

    exec_pipe #(
        .UNIT    (ALU_UNIT),
        .LATENCY (1)
    ) u_alu_pipe (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .dispatch_i (dispatch_i),
        .accept_i   (accept),
        .index_i    (assigned_index_o),
        .flush_i    (flush_commit),
        .wb_o       (wb[0])
    );

    exec_pipe #(
        .UNIT    (MUL_UNIT),
        .LATENCY (MUL_LATENCY)
    ) u_mul_pipe (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .dispatch_i (dispatch_i),
        .accept_i   (accept),
        .index_i    (assigned_index_o),
        .flush_i    (flush_commit),
        .wb_o       (wb[1])
    );

    commit_unit u_commit_unit (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .instruction_i   (gl_head),
        .commit_index_i  (commit_index),
        .empty_i         (gl_empty),
        .read_head_o     (read_head),
        .flush_commit_o  (flush_commit),
        .commit_o        (commit_o),
        .retired_count_o (retired_count_o)
    );

endmodule

/* graduation_list.sv */
`timescale 1ns/10ps

module graduation_list import gl_pkg::*; #(
    parameter int unsigned NUM_ENTRIES = 16 // Power of two, at most 2**GL_INDEX_W
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  gl_instruction_t         instruction_i,    // New entry from dispatch
    input  logic                    read_head_i,      // Request for the oldest entry
    input  wb_t [NUM_WB-1:0]        wb_i,             // Results from the pipes
    input  logic                    flush_commit_i,   // Drop everything in flight
    output gl_index_t               assigned_index_o, // Entry given to the new instruction
    output gl_instruction_t         instruction_o,    // Head, one cycle after the read
    output gl_index_t               commit_index_o,
    output logic                    full_o,
    output logic                    empty_o
);

    localparam int unsigned IDX_W = $clog2(NUM_ENTRIES);

    // One slot is always kept free
    localparam logic [IDX_W:0] FULL_LEVEL = (IDX_W + 1)'(NUM_ENTRIES - 1);

    typedef logic [IDX_W-1:0] ptr_t;

    ptr_t                   head_q;
    ptr_t                   tail_q;
    logic [IDX_W:0]         count_q;     // One bit wider than the pointers
    logic [NUM_ENTRIES-1:0] finished_q;  // Entry has its result
    gl_instruction_t        entries_q [NUM_ENTRIES];

    logic                   write_en;
    logic                   read_en;
    logic                   is_store;
    ptr_t                   wb_ptr [NUM_WB];

    // Registered head output
    logic                   out_valid_q;
    gl_instruction_t        out_q;
    gl_index_t              out_index_q;

    assign is_store = (instruction_i.instr_type == OP_STORE);

    assign write_en = instruction_i.valid & (count_q < FULL_LEVEL) & ~flush_commit_i;

    // The head leaves only once it is finished
    assign read_en = read_head_i & (count_q != '0) & finished_q[head_q] & ~flush_commit_i;

    always_comb begin
        for (int i = 0; i < NUM_WB; i++) begin
            wb_ptr[i] = wb_i[i].index[IDX_W-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_commit_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (write_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (read_en) begin
                head_q <= head_q + 1'b1;
            end
            case ({write_en, read_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    // Stores are finished as soon as they are inserted
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            finished_q <= '0;
        end else begin
            if (write_en) begin
                finished_q[tail_q] <= is_store;
            end
            for (int i = 0; i < NUM_WB; i++) begin
                if (wb_i[i].valid && !flush_commit_i) begin
                    finished_q[wb_ptr[i]] <= 1'b1;
                end
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries_q[tail_q] <= instruction_i;
        end
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_i[i].valid && !flush_commit_i) begin
                entries_q[wb_ptr[i]].result    <= wb_i[i].result;
                entries_q[wb_ptr[i]].exc_valid <= wb_i[i].exc_valid;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= read_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_en) begin
            out_q       <= entries_q[head_q];
            out_index_q <= gl_index_t'(head_q);
        end
    end

    always_comb begin
        instruction_o       = out_q;
        instruction_o.valid = out_valid_q; // Low in cycles without a read
    end

    assign commit_index_o   = out_index_q;
    assign assigned_index_o = gl_index_t'(tail_q);
    assign full_o           = (count_q == FULL_LEVEL);
    assign empty_o          = (count_q == '0);

endmodule

/* project.f */
gl_pkg.sv
graduation_list.sv
exec_pipe.sv
commit_unit.sv
gl_top.sv
gl_checker.sv
tb_gl_top.sv

/* tb_gl_top.sv */
`timescale 1ns/10ps

module tb_gl_top import gl_pkg::*; ();

    localparam int NUM_ENTRIES     = 16;
    localparam int MUL_LATENCY     = 16;  // Long enough that a waiting head lets the list fill
    localparam int NUM_MIXED       = 60;
    localparam int NUM_BURST       = 40;
    localparam int NUM_ROUNDS      = 2;
    localparam int ROUND_LEN       = 12;
    localparam int NUM_TRAIL       = 8;
    localparam int TOTAL_DISPATCH  = NUM_MIXED + NUM_BURST + NUM_ROUNDS * ROUND_LEN + NUM_TRAIL;
    localparam int WATCHDOG_CYCLES = TOTAL_DISPATCH * (MUL_LATENCY + NUM_ENTRIES + 4);

    logic        clk_i;
    logic        rstn_i;
    dispatch_t   dispatch;
    logic        dispatch_ready;
    gl_index_t   assigned_index;
    commit_t     commit;
    logic [31:0] retired_count;
    logic        done;
    addr_t       next_pc;
    int unsigned seed;
    int          error_count;
    int          good_count;
    int          exc_count;
    int          pending;

    gl_top #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .MUL_LATENCY (MUL_LATENCY)
    ) u_gl_top (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .dispatch_i       (dispatch),
        .dispatch_ready_o (dispatch_ready),
        .assigned_index_o (assigned_index),
        .commit_o         (commit),
        .retired_count_o  (retired_count)
    );

    gl_checker #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_gl_checker (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .dispatch_i       (dispatch),
        .dispatch_ready_i (dispatch_ready),
        .assigned_index_i (assigned_index),
        .commit_i         (commit),
        .retired_count_i  (retired_count),
        .done_i           (done),
        .error_count_o    (error_count),
        .good_count_o     (good_count),
        .exc_count_o      (exc_count),
        .pending_o        (pending)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;  // 100 ns period
    end

    // Hold one instruction on the bus until the DUT takes it
    task automatic send(instr_type_e op, data_t a, data_t b);
        dispatch_t d;
        logic      taken;
        d.valid      = 1'b1;
        d.instr_type = op;
        d.pc         = next_pc;
        d.src_a      = a;
        d.src_b      = b;
        taken        = 1'b0;
        next_pc      = next_pc + 32'd4;
        dispatch    <= d;
        while (!taken) begin
            @(negedge clk_i);
            taken = dispatch_ready;
            @(posedge clk_i);
        end
    endtask

    // Magnitude below 2**30 so two of them never overflow
    function automatic data_t small_operand();
        data_t v;
        v = $urandom & 32'h3fff_ffff;
        return ($urandom & 1) ? -v : v;
    endfunction

    task automatic send_random(int mul_pct);
        int pick;
        pick = int'($urandom % 100);
        if (pick < mul_pct) begin
            send(OP_MUL, $urandom, $urandom);
        end else if (pick < mul_pct + (100 - mul_pct) / 2) begin
            send(OP_ADD, small_operand(), small_operand());
        end else begin
            send(OP_STORE, $urandom, $urandom);
        end
    endtask

    task automatic idle(int n);
        dispatch <= '0;
        repeat (n) @(posedge clk_i);
    endtask

    task automatic drain();
        idle(1);
        while (pending != 0) @(posedge clk_i);
    endtask

    initial begin
        seed     = 32'h5b4b_a15f;
        seed     = $urandom(seed);
        dispatch = '0;
        done     = 1'b0;
        next_pc  = 32'h0000_1000;
        rstn_i   = 1'b0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;
        idle(3);  // Nothing may commit here
        repeat (NUM_MIXED) begin
            send_random(30);
            idle($urandom % 3);
        end
        repeat (NUM_BURST) send_random(80);  // Back to back and mostly multiplies
        drain();
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            repeat (4) send_random(50);
            if (r == 0) begin
                send(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
            end else begin
                send(OP_ADD, 32'h8000_0000, 32'hffff_ffff);
            end
            repeat (ROUND_LEN - 5) send_random(50);  // Younger ones get flushed
            drain();
        end
        repeat (NUM_TRAIL) send_random(30);
        drain();
        done <= 1'b1;
        @(negedge clk_i);
        @(posedge clk_i);
        $display("Retired %0d, exceptions %0d, errors %0d", good_count, exc_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog stopped the run after %0d cycles with %0d instructions not retired",
                 WATCHDOG_CYCLES, pending);
        $display("Retired %0d, exceptions %0d, errors %0d", good_count, exc_count, error_count);
        $display("Some tests failed");
        $finish;
    end

endmodule
